// File: common/core_defs.svh
`ifndef CORE_DEFS_SVH
`define CORE_DEFS_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// core sizing
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`define XLEN       32   // data and pc width
`define REG_COUNT  32   // x0 .. x31
`define REG_ADDR_W 5    // log2 of REG_COUNT

`endif

// File: common/core_pkg.sv
`include "core_defs.svh"

package core_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // rv32i base opcodes
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    typedef enum logic [6:0] {
        OP     = 7'b0110011,
        OP_IMM = 7'b0010011,
        LOAD   = 7'b0000011,
        STORE  = 7'b0100011,
        BRANCH = 7'b1100011,
        LUI    = 7'b0110111,
        AUIPC  = 7'b0010111,
        JAL    = 7'b1101111,
        JALR   = 7'b1100111
    } opcode_t;

    // funct3 under OP / OP_IMM
    typedef enum logic [2:0] {
        F3_ADD_SUB = 3'b000,
        F3_SLL     = 3'b001,
        F3_SLT     = 3'b010,
        F3_SLTU    = 3'b011,
        F3_XOR     = 3'b100,
        F3_SRL_SRA = 3'b101,
        F3_OR      = 3'b110,
        F3_AND     = 3'b111
    } funct3_t;

    typedef enum logic [2:0] {
        R_FMT, I_FMT, S_FMT, B_FMT, U_FMT, J_FMT, NONE_FMT
    } format_t;

    typedef enum logic [3:0] {
        ADD, SUB, AND, OR, XOR,
        SLL, SRL, SRA,
        SLT, SLTU,
        PASS_B          // lui result is the immediate
    } alu_op_t;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // instruction word views
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    typedef struct packed {
        logic [6:0]             funct7;
        logic [`REG_ADDR_W-1:0] rs2;
        logic [`REG_ADDR_W-1:0] rs1;
        logic [2:0]             funct3;
        logic [`REG_ADDR_W-1:0] rd;
        logic [6:0]             opcode;
    } r_type_t;

    typedef struct packed {
        logic [11:0]            imm;
        logic [`REG_ADDR_W-1:0] rs1;
        logic [2:0]             funct3;
        logic [`REG_ADDR_W-1:0] rd;
        logic [6:0]             opcode;
    } i_type_t;

    typedef struct packed {
        logic [6:0]             imm_hi;     // bits 31:25
        logic [`REG_ADDR_W-1:0] rs2;
        logic [`REG_ADDR_W-1:0] rs1;
        logic [2:0]             funct3;
        logic [4:0]             imm_lo;     // bits 11:7
        logic [6:0]             opcode;
    } s_type_t;

    typedef struct packed {
        logic [19:0]            imm;        // bits 31:12
        logic [`REG_ADDR_W-1:0] rd;
        logic [6:0]             opcode;
    } u_type_t;

    typedef union packed {
        r_type_t r;
        i_type_t i;
        s_type_t s;
        u_type_t u;
    } instr_t;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // stage payloads
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    typedef struct packed {
        instr_t            instr;
        logic [`XLEN-1:0]  pc;
    } fetch_t;

    typedef struct packed {
        logic [`XLEN-1:0]        pc;
        format_t                 format;
        alu_op_t                 alu_op;
        logic [`REG_ADDR_W-1:0]  rd;
        logic                    rd_we;
        logic                    illegal;
        logic signed [`XLEN-1:0] imm;
        logic [`XLEN-1:0]        rs1_data;
        logic [`XLEN-1:0]        rs2_data;
    } decoded_t;

endpackage

// File: dv/decode_model.svh
`ifndef DECODE_MODEL_SVH
`define DECODE_MODEL_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// rv32i decode reference
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

function automatic format_t format_of(input logic [31:0] w);
    case (w[6:0])
        7'b0110011: return R_FMT;
        7'b0010011, 7'b0000011, 7'b1100111: return I_FMT;
        7'b0100011: return S_FMT;
        7'b1100011: return B_FMT;
        7'b0110111, 7'b0010111: return U_FMT;
        7'b1101111: return J_FMT;
        default: return NONE_FMT;
    endcase
endfunction

function automatic logic [31:0] immediate_of(input logic [31:0] w);
    logic shamt_form;
    // funct3 001 and 101 share the low bits 01
    shamt_form = (w[6:0] == 7'b0010011) && (w[13:12] == 2'b01);
    case (format_of(w))
        I_FMT: return shamt_form ? {27'b0, w[24:20]} : {{20{w[31]}}, w[31:20]};
        S_FMT: return {{20{w[31]}}, w[31:25], w[11:7]};
        B_FMT: return {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
        U_FMT: return {w[31:12], 12'b0};
        J_FMT: return {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
        default: return 32'b0;
    endcase
endfunction

function automatic alu_op_t alu_op_of(input logic [31:0] w);
    logic is_reg;
    is_reg = (w[6:0] == 7'b0110011);
    if (is_reg || w[6:0] == 7'b0010011) begin
        case (w[14:12])
            3'b000: return (is_reg && w[30]) ? SUB : ADD;
            3'b001: return SLL;
            3'b010: return SLT;
            3'b011: return SLTU;
            3'b100: return XOR;
            3'b101: return w[30] ? SRA : SRL;
            3'b110: return OR;
            default: return AND;
        endcase
    end
    if (w[6:0] == 7'b1100011) begin
        return SUB;
    end
    if (w[6:0] == 7'b0110111) begin
        return PASS_B;
    end
    return ADD;
endfunction

function automatic logic writes_rd(input logic [31:0] w);
    format_t f;
    f = format_of(w);
    return (w[11:7] != 5'd0) && (f == R_FMT || f == I_FMT || f == U_FMT || f == J_FMT);
endfunction

`endif

// File: dv/tb_decode_stage.sv
`timescale 1ns/10ps
`include "core_defs.svh"

module tb_decode_stage;
    import core_pkg::*;

    `include "decode_model.svh"

    localparam int N_RANDOM  = 300;
    localparam int N_SHIFT   = 40;
    localparam int N_ILLEGAL = 24;
    localparam int N_WRITES  = 40;
    localparam int N_REGREAD = 64;
    localparam int N_STALL   = 150;
    localparam int N_LATENCY = 40;
    localparam int CYCLE_LIMIT = 4 * (N_RANDOM + N_SHIFT + N_ILLEGAL + N_WRITES
                                      + N_REGREAD + N_STALL + N_LATENCY) + 2 + 64;

    logic                    clk_i;
    logic                    rst_i;
    logic                    in_valid_i;
    logic                    in_ready_o;
    logic [`XLEN-1:0]        in_instr_i;
    logic [`XLEN-1:0]        in_pc_i;
    logic                    wb_we_i;
    logic [`REG_ADDR_W-1:0]  wb_addr_i;
    logic [`XLEN-1:0]        wb_data_i;
    logic                    out_valid_o;
    logic                    out_ready_i;
    logic [`XLEN-1:0]        out_pc_o;
    format_t                 out_format_o;
    alu_op_t                 out_alu_op_o;
    logic [`REG_ADDR_W-1:0]  out_rd_o;
    logic                    out_rd_we_o;
    logic                    out_illegal_o;
    logic signed [`XLEN-1:0] out_imm_o;
    logic [`XLEN-1:0]        out_rs1_data_o;
    logic [`XLEN-1:0]        out_rs2_data_o;

    decoded_t         expected_q[$];
    int               accept_cycle_q[$];
    logic [`XLEN-1:0] shadow_regs [`REG_COUNT];
    logic [`XLEN-1:0] next_pc = 32'h0000_1000;
    int               cycle_count = 0;
    int               checked_count = 0;
    int               compare_errors = 0;
    int               stim_errors = 0;
    int               checks_at;
    int               errors_at;
    logic             random_stall = 1'b0;
    logic             latency_mode = 1'b0;

    decode_stage dut0 (.*);

    initial begin
        clk_i = 1'b0;
        forever #20 clk_i = ~clk_i;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // stimulus helpers
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    function automatic decoded_t bundle_for(input logic [31:0] w, input logic [31:0] pc);
        decoded_t b;
        b.pc       = pc;
        b.format   = format_of(w);
        b.alu_op   = alu_op_of(w);
        b.rd       = w[11:7];
        b.rd_we    = writes_rd(w);
        b.illegal  = (b.format == NONE_FMT);
        b.imm      = immediate_of(w);
        b.rs1_data = shadow_regs[w[19:15]];   // x0 entry never written
        b.rs2_data = shadow_regs[w[24:20]];
        return b;
    endfunction

    function automatic logic [31:0] random_legal_word();
        logic [31:0] w;
        w = $urandom;
        case ($urandom % 9)
            0: w[6:0] = 7'b0110011;
            1: w[6:0] = 7'b0010011;
            2: w[6:0] = 7'b0000011;
            3: w[6:0] = 7'b0100011;
            4: w[6:0] = 7'b1100011;
            5: w[6:0] = 7'b0110111;
            6: w[6:0] = 7'b0010111;
            7: w[6:0] = 7'b1101111;
            default: w[6:0] = 7'b1100111;
        endcase
        if (w[6:0] == 7'b0110011) begin
            w[31:25] = {1'b0, w[30], 5'b0};
        end
        if (w[6:0] == 7'b0010011 && w[13:12] == 2'b01) begin
            w[31:25] = {1'b0, w[30] & w[14], 5'b0};   // slli never sets bit 30
        end
        return w;
    endfunction

    function automatic logic [31:0] shift_word();
        logic [31:0] w;
        w = $urandom;
        w[6:0] = 7'b0010011;
        case ($urandom % 3)
            0: w[31:25] = 7'b0000000;
            1: w[31:25] = 7'b0000000;
            default: w[31:25] = 7'b0100000;
        endcase
        w[14:12] = (w[30] || w[7]) ? 3'b101 : 3'b001;
        if (w[14:12] == 3'b001) begin
            w[30] = 1'b0;
        end
        return w;
    endfunction

    function automatic logic [31:0] illegal_word();
        logic [31:0] w;
        w = $urandom;
        case ($urandom % 6)
            0: w[6:0] = 7'b1110011;   // system
            1: w[6:0] = 7'b0001111;   // fence
            2: w[6:0] = 7'b0000000;
            3: w[6:0] = 7'b1111111;
            4: w[6:0] = 7'b0101111;   // amo
            default: w[6:0] = 7'b1010011;
        endcase
        return w;
    endfunction

    task automatic send_instr(input logic [31:0] w);
        logic accepted;
        accepted = 1'b0;
        in_valid_i = 1'b1;
        in_instr_i = w;
        in_pc_i = next_pc;
        while (!accepted) begin
            @(negedge clk_i);
            if (latency_mode && !in_ready_o) begin
                $display("input stalled at %0t while the output was never blocked", $time);
                stim_errors++;
            end
            if (in_ready_o) begin
                expected_q.push_back(bundle_for(w, next_pc));
                accept_cycle_q.push_back(cycle_count);
                accepted = 1'b1;
            end
            @(posedge clk_i);
            #2;
        end
        in_valid_i = 1'b0;
        next_pc = next_pc + 32'd4;
    endtask

    task automatic write_register(input logic [4:0] addr, input logic [31:0] data);
        wb_we_i = 1'b1;
        wb_addr_i = addr;
        wb_data_i = data;
        @(posedge clk_i);
        #2;
        wb_we_i = 1'b0;
        if (addr != 5'd0) begin
            shadow_regs[addr] = data;
        end
    endtask

    task automatic begin_test();
        checks_at = checked_count;
        errors_at = compare_errors + stim_errors;
    endtask

    task automatic end_test(input string name);
        while (expected_q.size() != 0) begin
            @(posedge clk_i);
        end
        @(posedge clk_i);
        #2;
        $display("test %s finished: %0d checked, %0d errors", name,
                 checked_count - checks_at, compare_errors + stim_errors - errors_at);
    endtask

    task automatic show_mismatch(input string name, input logic [31:0] want,
                                 input logic [31:0] got);
        $display("[ERROR] %0t %s expected %h got %h", $time, name, want, got);
        compare_errors++;
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // output compare
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    initial begin : compare_outputs
        decoded_t exp;
        int       accepted_at;
        forever begin
            @(negedge clk_i);
            if (out_valid_o && out_ready_i) begin   // transfer at the next edge
                if (expected_q.size() == 0) begin
                    $display("output at %0t with no instruction pending", $time);
                    compare_errors++;
                end else begin
                    exp = expected_q.pop_front();
                    accepted_at = accept_cycle_q.pop_front();
                    if (out_pc_o != exp.pc) begin
                        show_mismatch("out_pc_o", exp.pc, out_pc_o);
                    end
                    if (out_format_o != exp.format) begin
                        show_mismatch("out_format_o", 32'(exp.format), 32'(out_format_o));
                    end
                    if (out_alu_op_o != exp.alu_op) begin
                        show_mismatch("out_alu_op_o", 32'(exp.alu_op), 32'(out_alu_op_o));
                    end
                    if (out_rd_o != exp.rd) begin
                        show_mismatch("out_rd_o", 32'(exp.rd), 32'(out_rd_o));
                    end
                    if (out_rd_we_o != exp.rd_we) begin
                        show_mismatch("out_rd_we_o", 32'(exp.rd_we), 32'(out_rd_we_o));
                    end
                    if (out_illegal_o != exp.illegal) begin
                        show_mismatch("out_illegal_o", 32'(exp.illegal), 32'(out_illegal_o));
                    end
                    if (out_imm_o != exp.imm) begin
                        show_mismatch("out_imm_o", exp.imm, out_imm_o);
                    end
                    if (out_rs1_data_o != exp.rs1_data) begin
                        show_mismatch("out_rs1_data_o", exp.rs1_data, out_rs1_data_o);
                    end
                    if (out_rs2_data_o != exp.rs2_data) begin
                        show_mismatch("out_rs2_data_o", exp.rs2_data, out_rs2_data_o);
                    end
                    if (latency_mode && (cycle_count - accepted_at) != 2) begin
                        show_mismatch("latency", 32'd2, 32'(cycle_count - accepted_at));
                    end
                    checked_count++;
                end
            end
        end
    end

    // random back-pressure or always ready
    initial begin : stall_driver
        out_ready_i = 1'b1;
        forever begin
            @(posedge clk_i);
            #2;
            out_ready_i = random_stall ? (($urandom % 2) == 0) : 1'b1;
        end
    end

    initial begin : watchdog
        while (cycle_count <= CYCLE_LIMIT) begin
            @(posedge clk_i);
            cycle_count++;
        end
        $display("run timed out after %0d cycles without draining", cycle_count);
        $display("Some tests failed");
        $finish;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // test sequence
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    initial begin : main
        logic [31:0] w;
        void'($urandom(97891));
        rst_i = 1'b1;
        in_valid_i = 1'b0;
        in_instr_i = '0;
        in_pc_i = '0;
        wb_we_i = 1'b0;
        wb_addr_i = '0;
        wb_data_i = '0;
        for (int r = 0; r < `REG_COUNT; r++) begin
            shadow_regs[r] = '0;
        end
        repeat (2) @(posedge clk_i);
        #2;
        rst_i = 1'b0;
        @(negedge clk_i);
        if (!in_ready_o || out_valid_o) begin
            $display("after reset the input was not ready or the output was already valid");
            stim_errors++;
        end
        @(posedge clk_i);
        #2;

        begin_test();
        repeat (N_RANDOM) send_instr(random_legal_word());
        end_test("random_legal");

        begin_test();
        repeat (N_SHIFT) send_instr(shift_word());
        end_test("shift_imm");

        begin_test();
        repeat (N_ILLEGAL) send_instr(illegal_word());
        end_test("illegal_opcode");

        begin_test();
        for (int r = 0; r < `REG_COUNT; r++) begin
            write_register(r[4:0], $urandom);
        end
        write_register(5'd0, 32'hdead_beef);   // must be dropped
        repeat (N_WRITES - `REG_COUNT - 1) begin
            w = $urandom;
            write_register(w[4:0], $urandom);
        end
        for (int i = 0; i < N_REGREAD; i++) begin
            w = random_legal_word();
            w[19:15] = i[4:0];
            w[24:20] = ~w[19:15];
            send_instr(w);
        end
        end_test("register_read");

        begin_test();
        random_stall = 1'b1;
        for (int i = 0; i < N_STALL; i++) begin
            send_instr(random_legal_word());
            if (($urandom % 4) == 0) begin
                @(posedge clk_i);
                #2;
            end
        end
        random_stall = 1'b0;
        end_test("back_pressure");

        begin_test();
        latency_mode = 1'b1;
        repeat (N_LATENCY) send_instr(random_legal_word());
        end_test("latency");
        latency_mode = 1'b0;

        $display("summary: %0d instructions checked, %0d errors",
                 checked_count, compare_errors + stim_errors);
        if (compare_errors + stim_errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

// File: run_sim.sh
#!/bin/sh
# build and run the decode stage testbench with verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/10ps \
    -f src.f --top-module tb_decode_stage -Mdir obj_dir -o sim_decode
if [ $? -ne 0 ]; then
    echo "verilator compile failed"
    exit 1
fi

output=$(./obj_dir/sim_decode)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -q "All tests passed"; then
    exit 0
fi
exit 1

// File: src.f
+incdir+common
+incdir+dv
common/core_pkg.sv
src/pipe_reg.sv
src/format_decoder.sv
src/imm_generator.sv
src/reg_file.sv
src/decode_stage.sv
dv/tb_decode_stage.sv

// File: src/decode_stage.sv
`timescale 1ns/10ps
`include "core_defs.svh"

module decode_stage (
    input  logic                    clk_i,
    input  logic                    rst_i,
    // fetch side
    input  logic                    in_valid_i,
    output logic                    in_ready_o,
    input  logic [`XLEN-1:0]        in_instr_i,
    input  logic [`XLEN-1:0]        in_pc_i,
    // writeback
    input  logic                    wb_we_i,
    input  logic [`REG_ADDR_W-1:0]  wb_addr_i,
    input  logic [`XLEN-1:0]        wb_data_i,
    // decoded bundle
    output logic                    out_valid_o,
    input  logic                    out_ready_i,
    output logic [`XLEN-1:0]        out_pc_o,
    output core_pkg::format_t       out_format_o,
    output core_pkg::alu_op_t       out_alu_op_o,
    output logic [`REG_ADDR_W-1:0]  out_rd_o,
    output logic                    out_rd_we_o,
    output logic                    out_illegal_o,
    output logic signed [`XLEN-1:0] out_imm_o,
    output logic [`XLEN-1:0]        out_rs1_data_o,
    output logic [`XLEN-1:0]        out_rs2_data_o
);
    import core_pkg::*;

    fetch_t                  fetch_in;
    fetch_t                  fetch_q;
    logic                    fetch_valid;
    logic                    dec_ready;
    format_t                 fmt;
    alu_op_t                 alu_op;
    logic                    rd_we;
    logic                    illegal;
    logic signed [`XLEN-1:0] imm;
    logic [`XLEN-1:0]        rs1_data;
    logic [`XLEN-1:0]        rs2_data;
    decoded_t                dec_in;
    decoded_t                dec_q;

    assign fetch_in = '{instr: instr_t'(in_instr_i), pc: in_pc_i};

    pipe_reg #(.payload_t(fetch_t)) u_fetch_reg (
        .clk_i   (clk_i),
        .rst_i   (rst_i),
        .valid_i (in_valid_i),
        .ready_o (in_ready_o),
        .data_i  (fetch_in),
        .valid_o (fetch_valid),
        .ready_i (dec_ready),
        .data_o  (fetch_q)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // combinational decode
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    format_decoder u_format_decoder (
        .instr_i   (fetch_q.instr),
        .format_o  (fmt),
        .alu_op_o  (alu_op),
        .rd_we_o   (rd_we),
        .illegal_o (illegal)
    );

    imm_generator u_imm_generator (
        .instr_i  (fetch_q.instr),
        .format_i (fmt),
        .imm_o    (imm)
    );

    reg_file u_reg_file (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .rs1_addr_i (fetch_q.instr.r.rs1),
        .rs2_addr_i (fetch_q.instr.r.rs2),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data),
        .we_i       (wb_we_i),
        .wr_addr_i  (wb_addr_i),
        .wr_data_i  (wb_data_i)
    );

    assign dec_in = '{
        pc:       fetch_q.pc,
        format:   fmt,
        alu_op:   alu_op,
        rd:       fetch_q.instr.r.rd,
        rd_we:    rd_we,
        illegal:  illegal,
        imm:      imm,
        rs1_data: rs1_data,
        rs2_data: rs2_data
    };

    pipe_reg #(.payload_t(decoded_t)) u_decode_reg (
        .clk_i   (clk_i),
        .rst_i   (rst_i),
        .valid_i (fetch_valid),
        .ready_o (dec_ready),
        .data_i  (dec_in),
        .valid_o (out_valid_o),
        .ready_i (out_ready_i),
        .data_o  (dec_q)
    );

    assign out_pc_o       = dec_q.pc;
    assign out_format_o   = dec_q.format;
    assign out_alu_op_o   = dec_q.alu_op;
    assign out_rd_o       = dec_q.rd;
    assign out_rd_we_o    = dec_q.rd_we;
    assign out_illegal_o  = dec_q.illegal;
    assign out_imm_o      = dec_q.imm;
    assign out_rs1_data_o = dec_q.rs1_data;
    assign out_rs2_data_o = dec_q.rs2_data;

endmodule

// File: src/format_decoder.sv
`timescale 1ns/10ps

module format_decoder (
    input  core_pkg::instr_t  instr_i,
    output core_pkg::format_t format_o,
    output core_pkg::alu_op_t alu_op_o,
    output logic              rd_we_o,
    output logic              illegal_o
);
    import core_pkg::*;

    opcode_t opcode;
    funct3_t funct3;
    logic    alt;         // funct7 bit 30
    alu_op_t arith_op;

    assign opcode = opcode_t'(instr_i.r.opcode);
    assign funct3 = funct3_t'(instr_i.r.funct3);
    assign alt    = instr_i.r.funct7[5];

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // OP / OP_IMM operation select
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        case (funct3)
            F3_ADD_SUB: begin
                // addi has no sub form, bit 30 is immediate there
                arith_op = (alt && opcode == OP) ? SUB : ADD;
            end
            F3_SLL: begin
                arith_op = SLL;
            end
            F3_SLT: begin
                arith_op = SLT;
            end
            F3_SLTU: begin
                arith_op = SLTU;
            end
            F3_XOR: begin
                arith_op = XOR;
            end
            F3_SRL_SRA: begin
                arith_op = alt ? SRA : SRL;
            end
            F3_OR: begin
                arith_op = OR;
            end
            default: begin
                arith_op = AND;
            end
        endcase
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // opcode to format
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        format_o  = NONE_FMT;
        alu_op_o  = ADD;      // address / pc arithmetic
        illegal_o = 1'b0;
        case (opcode)
            OP: begin
                format_o = R_FMT;
                alu_op_o = arith_op;
            end
            OP_IMM: begin
                format_o = I_FMT;
                alu_op_o = arith_op;
            end
            LOAD, JALR: begin
                format_o = I_FMT;
            end
            STORE: begin
                format_o = S_FMT;
            end
            BRANCH: begin
                format_o = B_FMT;
                alu_op_o = SUB;   // compare by subtract
            end
            LUI: begin
                format_o = U_FMT;
                alu_op_o = PASS_B;
            end
            AUIPC: begin
                format_o = U_FMT;
            end
            JAL: begin
                format_o = J_FMT;
            end
            default: begin
                illegal_o = 1'b1; // system, fence, unused
            end
        endcase
    end

    // stores and branches have no rd
    assign rd_we_o = !illegal_o
                  && format_o != S_FMT
                  && format_o != B_FMT
                  && instr_i.r.rd != '0;

endmodule

// File: src/imm_generator.sv
`timescale 1ns/10ps
`include "core_defs.svh"

module imm_generator (
    input  core_pkg::instr_t        instr_i,
    input  core_pkg::format_t       format_i,
    output logic signed [`XLEN-1:0] imm_o
);
    import core_pkg::*;

    logic is_shift;

    // slli / srli / srai carry shamt in the low immediate bits
    assign is_shift = instr_i.i.opcode == OP_IMM
                   && (instr_i.i.funct3 == F3_SLL || instr_i.i.funct3 == F3_SRL_SRA);

    always_comb begin
        case (format_i)
            I_FMT: begin
                if (is_shift) begin
                    imm_o = {{(`XLEN-5){1'b0}}, instr_i.i.imm[4:0]};
                end else begin
                    imm_o = {{(`XLEN-12){instr_i.i.imm[11]}}, instr_i.i.imm};
                end
            end
            S_FMT: begin
                imm_o = {{(`XLEN-12){instr_i.s.imm_hi[6]}},
                         instr_i.s.imm_hi,
                         instr_i.s.imm_lo};
            end
            B_FMT: begin
                // 31, 7, 30:25, 11:8, then implicit zero
                imm_o = {{(`XLEN-13){instr_i.s.imm_hi[6]}},
                         instr_i.s.imm_hi[6],
                         instr_i.s.imm_lo[0],
                         instr_i.s.imm_hi[5:0],
                         instr_i.s.imm_lo[4:1],
                         1'b0};
            end
            U_FMT: begin
                imm_o = {instr_i.u.imm, 12'b0};
            end
            J_FMT: begin
                // u.imm[19] is bit 31, u.imm[8] is bit 20
                imm_o = {{(`XLEN-21){instr_i.u.imm[19]}},
                         instr_i.u.imm[19],
                         instr_i.u.imm[7:0],
                         instr_i.u.imm[8],
                         instr_i.u.imm[18:9],
                         1'b0};
            end
            default: begin
                imm_o = '0;       // r-type and illegal
            end
        endcase
    end

endmodule

// File: src/pipe_reg.sv
`timescale 1ns/10ps

module pipe_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk_i,
    input  logic     rst_i,
    // upstream side
    input  logic     valid_i,
    output logic     ready_o,
    input  payload_t data_i,
    // downstream side
    output logic     valid_o,
    input  logic     ready_i,
    output payload_t data_o
);

    logic     full_q;
    payload_t data_q;

    // load when empty or when the held item leaves this cycle
    assign ready_o = !full_q || ready_i;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            full_q <= 1'b0;
        end else if (ready_o) begin
            full_q <= valid_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (valid_i && ready_o) begin
            data_q <= data_i;   // payload, no reset
        end
    end

    assign valid_o = full_q;
    assign data_o  = data_q;

    // a stalled item must not change or vanish
    hold_while_stalled: assert property (
        @(posedge clk_i) disable iff (rst_i)
        valid_o && !ready_i |=> valid_o && $stable(data_o)
    );

endmodule

// File: src/reg_file.sv
`timescale 1ns/10ps
`include "core_defs.svh"

module reg_file (
    input  logic                   clk_i,
    input  logic                   rst_i,
    // read ports
    input  logic [`REG_ADDR_W-1:0] rs1_addr_i,
    input  logic [`REG_ADDR_W-1:0] rs2_addr_i,
    output logic [`XLEN-1:0]       rs1_data_o,
    output logic [`XLEN-1:0]       rs2_data_o,
    // write port
    input  logic                   we_i,
    input  logic [`REG_ADDR_W-1:0] wr_addr_i,
    input  logic [`XLEN-1:0]       wr_data_i
);

    logic [`XLEN-1:0] regs_q [`REG_COUNT];

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                regs_q[i] <= '0;
            end
        end else if (we_i && wr_addr_i != '0) begin
            regs_q[wr_addr_i] <= wr_data_i;   // x0 writes dropped
        end
    end

    // async read, no write bypass
    assign rs1_data_o = (rs1_addr_i == '0) ? '0 : regs_q[rs1_addr_i];
    assign rs2_data_o = (rs2_addr_i == '0) ? '0 : regs_q[rs2_addr_i];

    x0_reads_zero: assert property (
        @(posedge clk_i) disable iff (rst_i)
        rs1_addr_i == '0 |-> rs1_data_o == '0
    );

endmodule
